/* dv/tb_clk_gen.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held low for five rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* dv/tb_ext_port_wrap.sv */
// Testbench for ext_port_wrap: stimulus, far-side memory model, reference model and checker
`timescale 1ns/1ps

module tb_ext_port_wrap import ext_port_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;

  logic                                clk;
  logic                                rst_n;
  logic                                req_valid_i;
  logic                                req_ready_o;
  logic         [ADDR_WIDTH-1:0]       req_addr_i;
  logic         [DATA_WIDTH-1:0]       req_wdata_i;
  logic                                req_we_i;
  logic         [ID_WIDTH-1:0]         req_id_i;
  logic                                rsp_valid_o;
  logic                                rsp_ready_i;
  logic         [DATA_WIDTH-1:0]       rsp_rdata_o;
  logic         [ID_WIDTH-1:0]         rsp_id_o;
  logic                                rsp_err_o;
  logic                                isolate_i;
  logic                                isolated_o;
  req_payload_t [FIFO_DEPTH-1:0]       req_async_data_o;
  logic         [PTR_WIDTH-1:0]        req_async_wptr_o;
  logic         [PTR_WIDTH-1:0]        req_async_rptr_i;
  rsp_payload_t [FIFO_DEPTH-1:0]       rsp_async_data_i;
  logic         [PTR_WIDTH-1:0]        rsp_async_wptr_i;
  logic         [PTR_WIDTH-1:0]        rsp_async_rptr_o;

  integer                seed;
  int                    cycle_cnt;
  rsp_payload_t          exp_q[$];
  rsp_payload_t          exp_rsp;
  logic [DATA_WIDTH-1:0] ref_mem [256];
  logic                  ref_written [256];
  logic [DATA_WIDTH-1:0] far_mem [256];
  logic                  far_written [256];
  logic [PTR_WIDTH-1:0]  far_rbin;
  logic [PTR_WIDTH-1:0]  far_wbin;
  req_payload_t          far_req;
  rsp_payload_t          far_rsp;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  ext_port_wrap u_ext_port_wrap (
    .clk_i            ( clk              ),
    .rst_n_i          ( rst_n            ),
    .req_valid_i      ( req_valid_i      ),
    .req_ready_o      ( req_ready_o      ),
    .req_addr_i       ( req_addr_i       ),
    .req_wdata_i      ( req_wdata_i      ),
    .req_we_i         ( req_we_i         ),
    .req_id_i         ( req_id_i         ),
    .rsp_valid_o      ( rsp_valid_o      ),
    .rsp_ready_i      ( rsp_ready_i      ),
    .rsp_rdata_o      ( rsp_rdata_o      ),
    .rsp_id_o         ( rsp_id_o         ),
    .rsp_err_o        ( rsp_err_o        ),
    .isolate_i        ( isolate_i        ),
    .isolated_o       ( isolated_o       ),
    .req_async_data_o ( req_async_data_o ),
    .req_async_wptr_o ( req_async_wptr_o ),
    .req_async_rptr_i ( req_async_rptr_i ),
    .rsp_async_data_i ( rsp_async_data_i ),
    .rsp_async_wptr_i ( rsp_async_wptr_i ),
    .rsp_async_rptr_o ( rsp_async_rptr_o )
  );

  function automatic logic [PTR_WIDTH-1:0] to_gray(input logic [PTR_WIDTH-1:0] b);
    return b ^ (b >> 1);
  endfunction

  // Expected response from the memory rules
  function automatic rsp_payload_t ref_response(input logic [31:0] addr,
      input logic [31:0] wdata, input logic we, input logic [3:0] id, input logic iso);
    rsp_payload_t r;
    logic [7:0]   idx;
    idx     = addr[9:2];
    r.id    = id;
    r.err   = 1'b0;
    r.rdata = '0;
    if (iso) begin
      r.err = 1'b1;
    end else if (we) begin
      ref_mem[idx]     = wdata;
      ref_written[idx] = 1'b1;
    end else if (ref_written[idx]) begin
      r.rdata = ref_mem[idx];
    end else begin
      r.rdata = addr ^ 32'h5a5a5a5a;
    end
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  // Holds valid until accepted, leaves it high for back-to-back use
  task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata,
      input logic we, input logic [3:0] id);
    @(negedge clk);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_we_i    = we;
    req_id_i    = id;
    do @(posedge clk); while (!req_ready_o);
    exp_q.push_back(ref_response(addr, wdata, we, id, isolate_i));
  endtask

  task automatic idle_req();
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic send_random(input int n);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] we;
    for (int i = 0; i < n; i++) begin
      addr  = $random(seed) & 32'h0000_03fc;
      wdata = $random(seed);
      we    = $random(seed);
      send_req(addr, wdata, we[0], i[3:0]);
    end
    idle_req();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  // Far side: pops requests, applies them to memory, pushes responses
  always @(negedge clk) begin
    if (!rst_n) begin
      far_rbin         = '0;
      far_wbin         = '0;
      req_async_rptr_i = '0;
      rsp_async_wptr_i = '0;
    end else if (req_async_wptr_o != to_gray(far_rbin) &&
                 to_gray(far_wbin) != {~rsp_async_rptr_o[3:2], rsp_async_rptr_o[1:0]}) begin
      far_req       = req_async_data_o[far_rbin[LOG_DEPTH-1:0]];
      far_rsp.id    = far_req.id;
      far_rsp.err   = 1'b0;
      far_rsp.rdata = '0;
      if (far_req.we) begin
        far_mem[far_req.addr[9:2]]     = far_req.wdata;
        far_written[far_req.addr[9:2]] = 1'b1;
      end else if (far_written[far_req.addr[9:2]]) begin
        far_rsp.rdata = far_mem[far_req.addr[9:2]];
      end else begin
        far_rsp.rdata = far_req.addr ^ 32'h5a5a5a5a;
      end
      rsp_async_data_i[far_wbin[LOG_DEPTH-1:0]] = far_rsp;
      far_wbin         = far_wbin + 1'b1;
      far_rbin         = far_rbin + 1'b1;
      rsp_async_wptr_i = to_gray(far_wbin);
      req_async_rptr_i = to_gray(far_rbin);
    end
  end

  always @(posedge clk) begin
    if (rst_n && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("A response came back with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_val("rsp_rdata_o", rsp_rdata_o, exp_rsp.rdata);
        check_val("rsp_id_o", 32'(rsp_id_o), 32'(exp_rsp.id));
        check_val("rsp_err_o", 32'(rsp_err_o), 32'(exp_rsp.err));
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  initial begin
    seed             = 32'hc8c9ede6;
    cycle_cnt        = 0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    req_wdata_i      = '0;
    req_we_i         = 1'b0;
    req_id_i         = '0;
    rsp_ready_i      = 1'b1;
    isolate_i        = 1'b0;
    req_async_rptr_i = '0;
    rsp_async_data_i = '0;
    rsp_async_wptr_i = '0;
    for (int i = 0; i < 256; i++) begin
      ref_written[i] = 1'b0;
      far_written[i] = 1'b0;
    end

    wait (rst_n);
    @(negedge clk);
    check_val("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check_val("isolated_o", 32'(isolated_o), 32'h0);
    check_val("req_async_wptr_o", 32'(req_async_wptr_o), 32'h0);
    check_val("rsp_async_rptr_o", 32'(rsp_async_rptr_o), 32'h0);
    check_val("req_ready_o", 32'(req_ready_o), 32'h1);

    // Write then read back, then an unwritten word
    send_req(32'h0000_0040, 32'hdead_beef, 1'b1, 4'h1);
    send_req(32'h0000_0040, 32'h0, 1'b0, 4'h2);
    send_req(32'h0000_0080, 32'h0, 1'b0, 4'h3);
    idle_req();
    wait_drain();

    send_random(100);
    wait_drain();

    // Back-pressure until the request side stalls
    @(negedge clk);
    rsp_ready_i = 1'b0;
    fork
      send_random(20);
      begin
        do @(posedge clk); while (!(req_valid_i && !req_ready_o));
        repeat (10) @(negedge clk);
        rsp_ready_i = 1'b1;
      end
    join
    wait_drain();

    // Isolation with traffic outstanding
    @(negedge clk);
    rsp_ready_i = 1'b0;
    send_random(4);
    @(negedge clk);
    isolate_i = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_val("isolated_o", 32'(isolated_o), 32'h0);
    end
    rsp_ready_i = 1'b1;
    do @(posedge clk); while (!isolated_o);
    check_val("outstanding responses", exp_q.size(), 32'h0);
    send_random(3);
    wait_drain();
    @(negedge clk);
    isolate_i = 1'b0;
    do @(posedge clk); while (isolated_o);
    send_random(10);
    wait_drain();

    repeat (5) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("Expected responses never arrived");
    end
  end

endmodule

/* filelist.f */
hdl/ext_port_pkg.sv
hdl/mem_chan_if.sv
hdl/chan_isolate.sv
hdl/cdc_fifo_src.sv
hdl/cdc_fifo_dst.sv
hdl/ext_port_wrap.sv
dv/tb_clk_gen.sv
dv/tb_ext_port_wrap.sv

/* hdl/cdc_fifo_dst.sv */
// Read half of a gray-pointer async FIFO over remotely held storage
`timescale 1ns/1ps

module cdc_fifo_dst import ext_port_pkg::*; #(
  parameter type payload_t = rsp_payload_t
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  mem_chan_if.sub                         chan,
  input  payload_t [FIFO_DEPTH-1:0]       async_data_i,
  input  logic     [PTR_WIDTH-1:0]        async_wptr_i,
  output logic     [PTR_WIDTH-1:0]        async_rptr_o
);

  logic [SYNC_STAGES-1:0][PTR_WIDTH-1:0] wsync_q;
  logic [PTR_WIDTH-1:0]                  wptr_sync;
  logic [PTR_WIDTH-1:0]                  rptr_bin_q;
  logic [PTR_WIDTH-1:0]                  rptr_gray_q;
  logic [PTR_WIDTH-1:0]                  rptr_bin_next;
  logic                                  empty;
  logic                                  pop;

  // Remote write pointer into the local clock
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wsync_q <= '0;
    end else begin
      wsync_q[0] <= async_wptr_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        wsync_q[i] <= wsync_q[i-1];
      end
    end
  end

  assign wptr_sync = wsync_q[SYNC_STAGES-1];
  assign empty     = (rptr_gray_q == wptr_sync);

  // Head entry is read straight from the far-side storage
  assign chan.rsp_valid = !empty;
  assign chan.rsp       = async_data_i[rptr_bin_q[LOG_DEPTH-1:0]];

  assign pop           = chan.rsp_valid && chan.rsp_ready;
  assign rptr_bin_next = rptr_bin_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else if (pop) begin
      rptr_bin_q  <= rptr_bin_next;
      rptr_gray_q <= bin2gray(rptr_bin_next);
    end
  end

  assign async_rptr_o = rptr_gray_q;

  // An offered response means one to FIFO_DEPTH entries written by the far side
  a_valid_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    chan.rsp_valid |-> ((gray2bin(wptr_sync) - rptr_bin_q) != '0) &&
                       ((gray2bin(wptr_sync) - rptr_bin_q) <= PTR_WIDTH'(FIFO_DEPTH)));

endmodule

/* hdl/cdc_fifo_src.sv */
// Write half of a gray-pointer async FIFO with exposed storage and write pointer
`timescale 1ns/1ps

module cdc_fifo_src import ext_port_pkg::*; #(
  parameter type payload_t = req_payload_t
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  mem_chan_if.sub                         chan,
  output payload_t [FIFO_DEPTH-1:0]       async_data_o,
  output logic     [PTR_WIDTH-1:0]        async_wptr_o,
  input  logic     [PTR_WIDTH-1:0]        async_rptr_i
);

  payload_t [FIFO_DEPTH-1:0]         storage_q;
  logic     [PTR_WIDTH-1:0]          wptr_bin_q;
  logic     [PTR_WIDTH-1:0]          wptr_gray_q;
  logic     [PTR_WIDTH-1:0]          wptr_bin_next;
  logic     [SYNC_STAGES-1:0][PTR_WIDTH-1:0] rsync_q;
  logic     [PTR_WIDTH-1:0]          rptr_sync;
  logic                              full;
  logic                              push;

  // Remote read pointer into the local clock
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsync_q <= '0;
    end else begin
      rsync_q[0] <= async_rptr_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        rsync_q[i] <= rsync_q[i-1];
      end
    end
  end

  assign rptr_sync = rsync_q[SYNC_STAGES-1];

  // Full when the pointers differ only in the top two gray bits
  assign full = (wptr_gray_q == {~rptr_sync[PTR_WIDTH-1 -: 2], rptr_sync[PTR_WIDTH-3:0]});

  assign chan.req_ready = !full;
  assign push           = chan.req_valid && !full;
  assign wptr_bin_next  = wptr_bin_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (push) begin
      wptr_bin_q  <= wptr_bin_next;
      wptr_gray_q <= bin2gray(wptr_bin_next);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      storage_q[wptr_bin_q[LOG_DEPTH-1:0]] <= chan.req;
    end
  end

  assign async_data_o = storage_q;
  assign async_wptr_o = wptr_gray_q;

  // A write must never land on a slot the far side has yet to read
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> ((wptr_bin_q - gray2bin(rptr_sync)) < PTR_WIDTH'(FIFO_DEPTH)));

endmodule

/* hdl/chan_isolate.sv */
// Isolation gate with outstanding counter and local error termination
`timescale 1ns/1ps

module chan_isolate import ext_port_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  req_payload_t req_i,
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,
  output rsp_payload_t rsp_o,
  input  logic         isolate_i,
  output logic         isolated_o,
  mem_chan_if.mgr      chan
);

  logic [PEND_WIDTH-1:0] pend_q;
  logic                  isolated_q;
  logic                  err_valid_q;
  logic [ID_WIDTH-1:0]   err_id_q;
  logic                  fwd_en;
  logic                  fwd;
  logic                  ret;
  logic                  local_acc;

  // Forward only when open and below the outstanding limit
  assign fwd_en = !isolate_i && !isolated_q && (pend_q != PEND_WIDTH'(MAX_PENDING));

  assign chan.req_valid = req_valid_i && fwd_en;
  assign chan.req       = req_i;

  // Local termination takes one request at a time
  assign local_acc   = isolated_q && !err_valid_q && req_valid_i;
  assign req_ready_o = isolated_q ? !err_valid_q : (chan.req_ready && fwd_en);

  // Held error response goes out first, far side waits behind it
  assign chan.rsp_ready = rsp_ready_i && !err_valid_q;
  assign rsp_valid_o    = err_valid_q || chan.rsp_valid;
  assign rsp_o          = err_valid_q ?
                          rsp_payload_t'{rdata: '0, id: err_id_q, err: 1'b1} : chan.rsp;

  assign fwd = chan.req_valid && chan.req_ready;
  assign ret = chan.rsp_valid && chan.rsp_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      case ({fwd, ret})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase
    end
  end

  // Isolated once drained, released right after isolate_i drops
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      isolated_q <= 1'b0;
    end else if (!isolate_i) begin
      isolated_q <= 1'b0;
    end else if (pend_q == '0) begin
      isolated_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else if (local_acc) begin
      err_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (local_acc) begin
      err_id_q <= req_i.id;
    end
  end

  assign isolated_o = isolated_q;

  // Far side must never return more than was sent, nor exceed the limit
  a_pend_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((pend_q == '0) |-> !ret) and
    ((pend_q == PEND_WIDTH'(MAX_PENDING)) |-> !fwd));

  // Nothing outstanding and nothing forwarded while isolated
  a_quiet_isolated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated_q |-> (pend_q == '0) && !fwd);

endmodule

/* hdl/ext_port_pkg.sv */
// Port widths, FIFO geometry, request/response payload types and gray code helpers
package ext_port_pkg;

  // Channel widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ID_WIDTH   = 4;

  // Async FIFO geometry
  localparam int unsigned LOG_DEPTH   = 3;
  localparam int unsigned FIFO_DEPTH  = 1 << LOG_DEPTH;
  localparam int unsigned PTR_WIDTH   = LOG_DEPTH + 1;
  localparam int unsigned SYNC_STAGES = 2;

  // Isolation gate outstanding limit
  localparam int unsigned MAX_PENDING = 8;
  localparam int unsigned PEND_WIDTH  = 4;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  we;
    logic [ID_WIDTH-1:0]   id;
  } req_payload_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic [ID_WIDTH-1:0]   id;
    logic                  err;
  } rsp_payload_t;

  localparam int unsigned REQ_WIDTH = $bits(req_payload_t);
  localparam int unsigned RSP_WIDTH = $bits(rsp_payload_t);

  function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [PTR_WIDTH-1:0] gray2bin(input logic [PTR_WIDTH-1:0] gray);
    logic [PTR_WIDTH-1:0] bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* hdl/ext_port_wrap.sv */
// External memory port wrapper: isolation gate plus request and response FIFO halves
`timescale 1ns/1ps

module ext_port_wrap import ext_port_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Local request channel
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  logic [ADDR_WIDTH-1:0]             req_addr_i,
  input  logic [DATA_WIDTH-1:0]             req_wdata_i,
  input  logic                              req_we_i,
  input  logic [ID_WIDTH-1:0]               req_id_i,
  // Local response channel
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic [DATA_WIDTH-1:0]             rsp_rdata_o,
  output logic [ID_WIDTH-1:0]               rsp_id_o,
  output logic                              rsp_err_o,
  // Isolation control
  input  logic                              isolate_i,
  output logic                              isolated_o,
  // Async request FIFO, far side reads
  output req_payload_t [FIFO_DEPTH-1:0]     req_async_data_o,
  output logic         [PTR_WIDTH-1:0]      req_async_wptr_o,
  input  logic         [PTR_WIDTH-1:0]      req_async_rptr_i,
  // Async response FIFO, far side writes
  input  rsp_payload_t [FIFO_DEPTH-1:0]     rsp_async_data_i,
  input  logic         [PTR_WIDTH-1:0]      rsp_async_wptr_i,
  output logic         [PTR_WIDTH-1:0]      rsp_async_rptr_o
);

  req_payload_t req_pkt;
  rsp_payload_t rsp_pkt;

  assign req_pkt = '{
    addr:  req_addr_i,
    wdata: req_wdata_i,
    we:    req_we_i,
    id:    req_id_i
  };

  assign rsp_rdata_o = rsp_pkt.rdata;
  assign rsp_id_o    = rsp_pkt.id;
  assign rsp_err_o   = rsp_pkt.err;

  // Gated channel between the isolation gate and the crossings
  mem_chan_if iso_chan ();

  chan_isolate u_isolate (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_i       ( req_pkt     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_o       ( rsp_pkt     ),
    .isolate_i   ( isolate_i   ),
    .isolated_o  ( isolated_o  ),
    .chan        ( iso_chan    )
  );

  cdc_fifo_src #(
    .payload_t ( req_payload_t )
  ) u_req_src (
    .clk_i        ( clk_i            ),
    .rst_n_i      ( rst_n_i          ),
    .chan         ( iso_chan         ),
    .async_data_o ( req_async_data_o ),
    .async_wptr_o ( req_async_wptr_o ),
    .async_rptr_i ( req_async_rptr_i )
  );

  cdc_fifo_dst #(
    .payload_t ( rsp_payload_t )
  ) u_rsp_dst (
    .clk_i        ( clk_i            ),
    .rst_n_i      ( rst_n_i          ),
    .chan         ( iso_chan         ),
    .async_data_i ( rsp_async_data_i ),
    .async_wptr_i ( rsp_async_wptr_i ),
    .async_rptr_o ( rsp_async_rptr_o )
  );

endmodule

/* hdl/mem_chan_if.sv */
// Request/response memory channel interface with manager and subordinate modports
`timescale 1ns/1ps

interface mem_chan_if import ext_port_pkg::*; ();

  // Request channel
  logic         req_valid;
  logic         req_ready;
  req_payload_t req;

  // Response channel
  logic         rsp_valid;
  logic         rsp_ready;
  rsp_payload_t rsp;

  modport mgr (
    output req_valid,
    input  req_ready,
    output req,
    input  rsp_valid,
    output rsp_ready,
    input  rsp
  );

  modport sub (
    input  req_valid,
    output req_ready,
    input  req,
    output rsp_valid,
    input  rsp_ready,
    output rsp
  );

endinterface
